/* hw/st_cfg_pkg.sv */
// st glue config package
// OSD system setting encodings shared by the glue block and its testbench

`default_nettype none

package st_cfg_pkg;

  localparam int unsigned mouse_src_w = 2; // port 0 mouse source select
  localparam int unsigned joy_src_w   = 1; // joystick assignment select
  localparam int unsigned volume_w    = 2; // four volume steps

  // where the port 0 mouse comes from
  typedef enum logic [mouse_src_w-1:0] {
    MOUSE_USB       = 2'd0, // usb hid mouse via mcu
    MOUSE_DB9_ATARI = 2'd1, // atari mouse on the db9 pins
    MOUSE_DB9_AMIGA = 2'd2, // amiga mouse, vertical pins swapped
    MOUSE_OFF       = 2'd3  // no mouse at all
  } mouse_src_e;

  // which hid joystick lands on port 0
  typedef enum logic [joy_src_w-1:0] {
    JOY_HID1_ON_PORT0 = 1'b0,
    JOY_HID0_ON_PORT0 = 1'b1
  } joy_src_e;

  // audio attenuation
  typedef enum logic [volume_w-1:0] {
    VOL_MUTE    = 2'd0,
    VOL_QUARTER = 2'd1, // >>> 2
    VOL_HALF    = 2'd2, // >>> 1
    VOL_FULL    = 2'd3
  } volume_e;

endpackage

`default_nettype wire

/* hw/st_io_pkg.sv */
// st glue io package
// port, address and audio widths plus boot timing

`default_nettype none

package st_io_pkg;

  // controller ports
  localparam int unsigned db9_w     = 6; // 4 directions + 2 buttons
  localparam int unsigned hid_joy_w = 8; // 4 directions + 4 buttons
  localparam int unsigned joy1_w    = 5; // st port 1 has a single fire

  // ram word address, bits 23..1
  localparam int unsigned ram_addr_w  = 23;
  localparam int unsigned scramble_lo = 3; // lowest scrambled address bit

  // audio
  localparam int unsigned audio_in_w  = 15; // st mixer output
  localparam int unsigned audio_out_w = 16; // dac side

  // sd image size as reported by the mcu
  localparam int unsigned img_size_w = 64;

  // 2 s at 32 MHz before booting without an image
  localparam int unsigned sd_wait_cycles = 64_000_000;

endpackage

`default_nettype wire

/* hw/joy_port_mixer.sv */
// controller port mixer
// routes db9 pins and usb hid reports onto the two st joystick ports

`default_nettype none
`timescale 1ns/1ps

module joy_port_mixer (
  input  wire logic                           clk32,
  input  wire logic                           rst,
  input  wire logic [st_io_pkg::db9_w-1:0]    io,        // db9 port 1, active low
  input  wire logic [st_io_pkg::db9_w-1:0]    spare,     // db9 port 2, active low
  input  wire logic [st_io_pkg::db9_w-1:0]    hid_mouse,
  input  wire logic [st_io_pkg::hid_joy_w-1:0] hid_joy0,
  input  wire logic [st_io_pkg::hid_joy_w-1:0] hid_joy1,
  input  wire st_cfg_pkg::mouse_src_e         port_mouse,
  input  wire st_cfg_pkg::joy_src_e           port_joy,
  output logic      [st_io_pkg::db9_w-1:0]    joy0,
  output logic      [st_io_pkg::joy1_w-1:0]   joy1,
  output logic      [st_io_pkg::db9_w-1:0]    db9_joy    // db9 events for the mcu
);

  // atari pinout, pins are active low
  function automatic logic [st_io_pkg::db9_w-1:0] atari_map(
    input logic [st_io_pkg::db9_w-1:0] pins
  );
    return ~{pins[5], pins[0], pins[2], pins[1], pins[4], pins[3]};
  endfunction

  // amiga mouse swaps two of the direction pins
  function automatic logic [st_io_pkg::db9_w-1:0] amiga_map(
    input logic [st_io_pkg::db9_w-1:0] pins
  );
    return ~{pins[5], pins[0], pins[3], pins[1], pins[4], pins[2]};
  endfunction

  logic [st_io_pkg::db9_w-1:0] db9_atari; // io as atari device
  logic [st_io_pkg::db9_w-1:0] db9_joy2;  // spare as atari device
  logic [st_io_pkg::db9_w-1:0] mouse_sel; // port 0 mouse candidate
  logic [st_io_pkg::db9_w-1:0] joy_sel;   // port 0 joystick candidate
  logic                        mouse_active;

  assign db9_atari = atari_map(io);
  assign db9_joy2  = atari_map(spare);

  always_comb begin
    case (port_mouse)
      st_cfg_pkg::MOUSE_USB:       mouse_sel = hid_mouse;
      st_cfg_pkg::MOUSE_DB9_ATARI: mouse_sel = db9_atari;
      st_cfg_pkg::MOUSE_DB9_AMIGA: mouse_sel = amiga_map(io);
      default:                     mouse_sel = '0; // mouse off
    endcase
  end

  assign joy_sel = (port_joy == st_cfg_pkg::JOY_HID0_ON_PORT0) ?
                   hid_joy0[st_io_pkg::db9_w-1:0] :
                   {1'b0, hid_joy1[st_io_pkg::joy1_w-1:0]}; // second fire unused

  // mouse and joystick share port 0, last device to press a fire wins
  always_ff @(posedge clk32) begin
    if (rst) begin
      mouse_active <= 1'b1; // mouse owns the port after reset
    end else if (!mouse_active && (mouse_sel[5] || mouse_sel[4])) begin
      mouse_active <= 1'b1;
    end else if (mouse_active && (joy_sel[5] || joy_sel[4])) begin
      mouse_active <= 1'b0;
    end
  end

  // mice hold some lines active, so gate rather than just OR them in
  assign joy0 = joy_sel | (mouse_active ? mouse_sel : '0);

  // db9 is free for a joystick only when the mouse comes over usb
  assign db9_joy = (port_mouse == st_cfg_pkg::MOUSE_USB) ? db9_atari : '0;

  // port 1 is plain wired-or of hid and db9
  assign joy1 = (port_joy == st_cfg_pkg::JOY_HID0_ON_PORT0) ?
                (hid_joy1[st_io_pkg::joy1_w-1:0] | db9_joy2[st_io_pkg::joy1_w-1:0]) :
                (hid_joy0[st_io_pkg::joy1_w-1:0] | db9_joy[st_io_pkg::joy1_w-1:0]);

  // ownership only moves on a fire press
  a_mouse_active_hold: assert property (@(posedge clk32) disable iff (rst)
    !(mouse_sel[5] || mouse_sel[4] || joy_sel[5] || joy_sel[4]) |=> $stable(mouse_active));

endmodule

`default_nettype wire

/* hw/boot_gate.sv */
// boot release gate
// holds the st in reset until memories and the sd image are ready, with timeout

`default_nettype none
`timescale 1ns/1ps

module boot_gate #(
  parameter int unsigned wait_cycles = st_io_pkg::sd_wait_cycles
) (
  input  wire logic                             clk32,
  input  wire logic                             rst,
  input  wire logic                             sys_reset,   // osd reset
  input  wire logic                             reset_btn,
  input  wire logic                             ram_ready,
  input  wire logic                             flash_ready,
  input  wire logic [st_io_pkg::img_size_w-1:0] img_size,    // nonzero once mounted
  output logic                                  st_resetn
);

  localparam int unsigned cnt_w = $clog2(wait_cycles + 1);

  logic [cnt_w-1:0] sd_wait; // cycles spent waiting for an image
  logic             sd_ready;

  // give the mcu time to mount a default image before booting
  always_ff @(posedge clk32) begin
    if (rst) begin
      sd_wait  <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != '0) begin
        sd_ready <= 1'b1; // image present
      end
      if (sd_wait < cnt_w'(wait_cycles)) begin
        sd_wait <= sd_wait + 1'b1;
      end else begin
        sd_ready <= 1'b1; // gave up waiting, boot without image
      end
    end
  end

  // every reset source and readiness flag must agree
  assign st_resetn = !rst && !sys_reset && !reset_btn &&
                     ram_ready && flash_ready && sd_ready;

  // once released by image or timeout the gate stays open
  a_sd_ready_sticky: assert property (@(posedge clk32)
    !rst && sd_ready |=> sd_ready);

endmodule

`default_nettype wire

/* hw/ram_scrambler.sv */
// cold-boot ram scrambler
// xors two word address bits with a counter bumped on every coldboot request

`default_nettype none
`timescale 1ns/1ps

module ram_scrambler (
  input  wire logic                          clk32,
  input  wire logic                          rst,
  input  wire logic                          coldboot,  // osd coldboot level
  input  wire logic [st_io_pkg::ram_addr_w:1] ram_a,     // word address from st
  output logic      [st_io_pkg::ram_addr_w:1] ram_a_s    // address to sdram
);

  logic       cb_d;     // coldboot one cycle ago
  logic [1:0] scramble; // wraps after four requests
  logic [st_io_pkg::ram_addr_w:1] scr_mask;

  // a new mapping makes old ram contents look like garbage
  always_ff @(posedge clk32) begin
    if (rst) begin
      cb_d     <= 1'b0;
      scramble <= 2'd0;
    end else begin
      cb_d <= coldboot;
      if (coldboot && !cb_d) begin
        scramble <= scramble + 2'd1; // rising edge only
      end
    end
  end

  always_comb begin
    scr_mask = '0;
    scr_mask[st_io_pkg::scramble_lo +: 2] = scramble; // bits 4..3
  end

  assign ram_a_s = ram_a ^ scr_mask;

  a_scramble_on_edge: assert property (@(posedge clk32) disable iff (rst)
    !(coldboot && !cb_d) |=> $stable(scramble));

endmodule

`default_nettype wire

/* hw/audio_volume.sv */
// audio volume stage
// sign-extends the st stereo mix and scales it in four steps, registered

`default_nettype none
`timescale 1ns/1ps

module audio_volume (
  input  wire logic                              clk32,
  input  wire logic                              rst,
  input  wire logic [st_io_pkg::audio_in_w-1:0]  audio_l_in,
  input  wire logic [st_io_pkg::audio_in_w-1:0]  audio_r_in,
  input  wire st_cfg_pkg::volume_e               volume,
  output logic      [st_io_pkg::audio_out_w-1:0] audio_l,
  output logic      [st_io_pkg::audio_out_w-1:0] audio_r
);

  // widen then divide by a power of two, sign preserved
  function automatic logic [st_io_pkg::audio_out_w-1:0] scale(
    input logic [st_io_pkg::audio_in_w-1:0] sample,
    input st_cfg_pkg::volume_e              vol
  );
    logic signed [st_io_pkg::audio_out_w-1:0] ext;
    ext = {{(st_io_pkg::audio_out_w - st_io_pkg::audio_in_w){sample[st_io_pkg::audio_in_w-1]}},
           sample};
    case (vol)
      st_cfg_pkg::VOL_MUTE:    return '0;
      st_cfg_pkg::VOL_QUARTER: return ext >>> 2;
      st_cfg_pkg::VOL_HALF:    return ext >>> 1;
      default:                 return ext; // full scale
    endcase
  endfunction

  always_ff @(posedge clk32) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= scale(audio_l_in, volume); // new sample every clock
      audio_r <= scale(audio_r_in, volume);
    end
  end

  a_mute_silent: assert property (@(posedge clk32) disable iff (rst)
    volume == st_cfg_pkg::VOL_MUTE |=> (audio_l == '0) && (audio_r == '0));

endmodule

`default_nettype wire

/* hw/st_glue_top.sv */
// atari st glue top level
// controller mixing, boot gating, ram scrambling and audio volume on clk32

`default_nettype none
`timescale 1ns/1ps

module st_glue_top #(
  parameter int unsigned wait_cycles = st_io_pkg::sd_wait_cycles // sd image timeout
) (
  input  wire logic                              clk32,
  input  wire logic                              rst,
  // controllers
  input  wire logic [st_io_pkg::db9_w-1:0]       io,
  input  wire logic [st_io_pkg::db9_w-1:0]       spare,
  input  wire logic [st_io_pkg::db9_w-1:0]       hid_mouse,
  input  wire logic [st_io_pkg::hid_joy_w-1:0]   hid_joy0,
  input  wire logic [st_io_pkg::hid_joy_w-1:0]   hid_joy1,
  input  wire st_cfg_pkg::mouse_src_e            port_mouse,
  input  wire st_cfg_pkg::joy_src_e              port_joy,
  // boot control
  input  wire logic                              sys_reset, // osd reset bit 0
  input  wire logic                              coldboot,  // osd reset bit 1
  input  wire logic                              reset_btn,
  input  wire logic                              ram_ready,
  input  wire logic                              flash_ready,
  input  wire logic [st_io_pkg::img_size_w-1:0]  img_size,
  // ram address
  input  wire logic [st_io_pkg::ram_addr_w:1]    ram_a,
  // audio
  input  wire logic [st_io_pkg::audio_in_w-1:0]  audio_l_in,
  input  wire logic [st_io_pkg::audio_in_w-1:0]  audio_r_in,
  input  wire st_cfg_pkg::volume_e               volume,
  // outputs
  output logic      [st_io_pkg::db9_w-1:0]       joy0,
  output logic      [st_io_pkg::joy1_w-1:0]      joy1,
  output logic      [st_io_pkg::db9_w-1:0]       db9_joy,
  output logic                                   st_resetn,
  output logic      [st_io_pkg::ram_addr_w:1]    ram_a_s,
  output logic      [st_io_pkg::audio_out_w-1:0] audio_l,
  output logic      [st_io_pkg::audio_out_w-1:0] audio_r
);

  // input side
  joy_port_mixer i_joy_port_mixer (
    .clk32, .rst, .io, .spare, .hid_mouse, .hid_joy0, .hid_joy1,
    .port_mouse, .port_joy, .joy0, .joy1, .db9_joy
  );

  // processing, both run side by side
  boot_gate #(
    .wait_cycles(wait_cycles)
  ) i_boot_gate (
    .clk32, .rst, .sys_reset, .reset_btn, .ram_ready, .flash_ready,
    .img_size, .st_resetn
  );

  ram_scrambler i_ram_scrambler (
    .clk32, .rst, .coldboot, .ram_a, .ram_a_s
  );

  // output side
  audio_volume i_audio_volume (
    .clk32, .rst, .audio_l_in, .audio_r_in, .volume, .audio_l, .audio_r
  );

endmodule

`default_nettype wire

/* verification/st_glue_tb.sv */
// st glue testbench
// random stimulus, reference models and concurrent checks for st_glue_top

`default_nettype none
`timescale 1ns/1ps

module st_glue_tb;

  localparam int unsigned tb_wait      = 200;          // short sd timeout
  localparam int unsigned reset_cycles = 8;
  localparam int unsigned n_a          = tb_wait + 40; // timeout phase
  localparam int unsigned n_b          = 300;          // image phase
  localparam int unsigned limit_cycles = 20 * (n_a + n_b + 2 * reset_cycles + tb_wait);

  logic clk32 = 1'b0;
  logic rst, sys_reset, coldboot, reset_btn, ram_ready, flash_ready;
  logic st_resetn;
  logic [st_io_pkg::db9_w-1:0] io, spare, hid_mouse, joy0, db9_joy;
  logic [st_io_pkg::hid_joy_w-1:0] hid_joy0, hid_joy1;
  logic [st_io_pkg::joy1_w-1:0] joy1;
  logic [st_io_pkg::img_size_w-1:0] img_size;
  logic [st_io_pkg::ram_addr_w:1] ram_a, ram_a_s, exp_ram_a_s;
  logic [st_io_pkg::audio_in_w-1:0] audio_l_in, audio_r_in;
  logic [st_io_pkg::audio_out_w-1:0] audio_l, audio_r;
  logic [st_io_pkg::audio_out_w-1:0] m_aud_l = '0, m_aud_r = '0; // one-cycle audio model
  st_cfg_pkg::mouse_src_e port_mouse;
  st_cfg_pkg::joy_src_e   port_joy;
  st_cfg_pkg::volume_e    volume;
  logic [st_io_pkg::db9_w-1:0] atari_io, atari_spare, exp_mouse, exp_joy, exp_joy0, exp_db9;
  logic [st_io_pkg::joy1_w-1:0] exp_joy1;
  logic m_mouse_active = 1'b1, m_ready = 1'b0, m_cb_d = 1'b0, exp_resetn, allow_resets;
  logic [1:0] m_scr = 2'd0;    // model scramble counter
  int m_wait = 0;
  int errors = 0, n_to_joy = 0, n_to_mouse = 0, n_wraps = 0;
  int seed = 32'h73f0_0c7a;

  st_glue_top #(.wait_cycles(tb_wait)) i_dut (.*);

  initial begin
    forever #20 clk32 = ~clk32; // 40 ns period
  end

  // db9 pins are active low, bit order per atari pinout
  function automatic logic [5:0] pins_atari(input logic [5:0] p);
    logic [5:0] r;
    r[5] = ~p[5];
    r[4] = ~p[0];
    r[3] = ~p[2];
    r[2] = ~p[1];
    r[1] = ~p[4];
    r[0] = ~p[3];
    return r;
  endfunction

  function automatic logic [5:0] pins_amiga(input logic [5:0] p);
    logic [5:0] r;
    r = pins_atari(p);
    r[3] = ~p[3]; // vertical lines swapped
    r[0] = ~p[2];
    return r;
  endfunction

  function automatic logic [15:0] scaled_sample(
    input logic [14:0] s,
    input st_cfg_pkg::volume_e v
  );
    logic signed [15:0] wide;
    wide = $signed({s[14], s});
    if (v == st_cfg_pkg::VOL_MUTE) return 16'd0;
    if (v == st_cfg_pkg::VOL_QUARTER) return wide >>> 2;
    if (v == st_cfg_pkg::VOL_HALF) return wide >>> 1;
    return wide;
  endfunction

  task automatic flag_value_error(
    input string name,
    input logic [63:0] exp,
    input logic [63:0] got
  );
    errors++;
    $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
  endtask

  // expected combinational outputs
  assign atari_io    = pins_atari(io);
  assign atari_spare = pins_atari(spare);
  assign exp_mouse = (port_mouse == st_cfg_pkg::MOUSE_USB) ? hid_mouse :
                     (port_mouse == st_cfg_pkg::MOUSE_DB9_ATARI) ? atari_io :
                     (port_mouse == st_cfg_pkg::MOUSE_DB9_AMIGA) ? pins_amiga(io) : 6'd0;
  assign exp_joy  = port_joy ? hid_joy0[5:0] : {1'b0, hid_joy1[4:0]}; // 1 is hid0 on port 0
  assign exp_joy0 = exp_joy | (m_mouse_active ? exp_mouse : 6'd0);
  assign exp_db9  = (port_mouse == st_cfg_pkg::MOUSE_USB) ? atari_io : 6'd0;
  assign exp_joy1 = port_joy ? (hid_joy1[4:0] | atari_spare[4:0]) : (hid_joy0[4:0] | exp_db9[4:0]);
  assign exp_resetn = !rst && !sys_reset && !reset_btn && ram_ready && flash_ready && m_ready;

  always_comb begin
    exp_ram_a_s    = ram_a;
    exp_ram_a_s[4] = ram_a[4] ^ m_scr[1];
    exp_ram_a_s[3] = ram_a[3] ^ m_scr[0];
  end

  // registered models, read the same pre-edge inputs as the dut
  always @(posedge clk32) begin
    if (rst) begin
      m_mouse_active <= 1'b1;
      m_wait <= 0;
      m_ready <= 1'b0;
      m_cb_d <= 1'b0;
      m_scr <= 2'd0;
      m_aud_l <= '0;
      m_aud_r <= '0;
    end else begin
      if (!m_mouse_active && (exp_mouse[5] || exp_mouse[4])) begin
        m_mouse_active <= 1'b1;
        n_to_mouse++;
      end else if (m_mouse_active && (exp_joy[5] || exp_joy[4])) begin
        m_mouse_active <= 1'b0;
        n_to_joy++;
      end
      if (!m_ready) m_wait <= m_wait + 1;
      if (!m_ready && (img_size != 0 || m_wait == tb_wait)) m_ready <= 1'b1;
      m_cb_d <= coldboot;
      if (coldboot && !m_cb_d) begin
        m_scr <= m_scr + 2'd1;
        if (m_scr == 2'd3) n_wraps++; // back to identity
      end
      m_aud_l <= scaled_sample(audio_l_in, volume);
      m_aud_r <= scaled_sample(audio_r_in, volume);
    end
  end

  a_joy0: assert property (@(posedge clk32) disable iff (rst) joy0 == exp_joy0)
    else flag_value_error("joy0", $sampled(exp_joy0), $sampled(joy0));
  a_joy1: assert property (@(posedge clk32) joy1 == exp_joy1)
    else flag_value_error("joy1", $sampled(exp_joy1), $sampled(joy1));
  a_db9: assert property (@(posedge clk32) db9_joy == exp_db9)
    else flag_value_error("db9_joy", $sampled(exp_db9), $sampled(db9_joy));
  a_resetn: assert property (@(posedge clk32) st_resetn == exp_resetn)
    else flag_value_error("st_resetn", $sampled(exp_resetn), $sampled(st_resetn));
  a_ram: assert property (@(posedge clk32) disable iff (rst) ram_a_s == exp_ram_a_s)
    else flag_value_error("ram_a_s", $sampled(exp_ram_a_s), $sampled(ram_a_s));
  a_aud_l: assert property (@(posedge clk32) disable iff (rst) audio_l == m_aud_l)
    else flag_value_error("audio_l", $sampled(m_aud_l), $sampled(audio_l));
  a_aud_r: assert property (@(posedge clk32) disable iff (rst) audio_r == m_aud_r)
    else flag_value_error("audio_r", $sampled(m_aud_r), $sampled(audio_r));

  task automatic randomize_inputs();
    logic [1:0] pick;
    io <= $random(seed);
    spare <= $random(seed);
    hid_mouse <= $random(seed);
    hid_joy0 <= $random(seed);
    hid_joy1 <= $random(seed);
    pick = $random(seed);
    port_mouse <= st_cfg_pkg::mouse_src_e'(pick);
    port_joy <= st_cfg_pkg::joy_src_e'($random(seed) & 1);
    pick = $random(seed);
    volume <= st_cfg_pkg::volume_e'(pick);
    coldboot <= $random(seed);
    ram_a <= $random(seed);
    audio_l_in <= $random(seed);
    audio_r_in <= $random(seed);
    if (allow_resets) begin
      sys_reset <= (($random(seed) & 15) == 0);
      reset_btn <= (($random(seed) & 15) == 0);
    end
  endtask

  task automatic run_reset();
    rst <= 1'b1;
    repeat (reset_cycles) @(posedge clk32);
    rst <= 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    {sys_reset, coldboot, reset_btn, allow_resets} = '0;
    {ram_ready, flash_ready} = 2'b11;
    {io, spare} = '1; // idle db9 lines float high
    {hid_mouse, hid_joy0, hid_joy1, img_size, ram_a, audio_l_in, audio_r_in} = '0;
    port_mouse = st_cfg_pkg::MOUSE_USB;
    port_joy   = st_cfg_pkg::JOY_HID0_ON_PORT0;
    volume     = st_cfg_pkg::VOL_FULL;
    run_reset();
    // no image ever shows up, release must come from the timeout
    repeat (n_a) begin
      @(posedge clk32);
      randomize_inputs();
    end
    if (!st_resetn) begin
      errors++;
      $display("boot gate was never released by the sd timeout");
    end
    @(posedge clk32);
    run_reset();
    for (int i = 0; i < n_b; i++) begin
      @(posedge clk32);
      randomize_inputs();
      if (i == 20) img_size <= {$random(seed), $random(seed)} | 64'd1;
      if (i == 60) allow_resets <= 1'b1; // release seen first, then reset pulses
    end
    @(posedge clk32);
    if (n_to_joy == 0 || n_to_mouse == 0) begin
      errors++;
      $display("port 0 arbitration did not switch both ways");
    end
    if (n_wraps == 0) begin
      errors++;
      $display("scramble counter never wrapped after four coldboot pulses");
    end
    $display("errors=%0d", errors);
    if (errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    #(limit_cycles * 40);
    $display("watchdog expired before the stimulus finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hw/st_cfg_pkg.sv
hw/st_io_pkg.sv
hw/joy_port_mixer.sv
hw/boot_gate.sv
hw/ram_scrambler.sv
hw/audio_volume.sv
hw/st_glue_top.sv
verification/st_glue_tb.sv

/* Bender.yml */
package:
  name: st_glue

sources:
  - hw/st_cfg_pkg.sv
  - hw/st_io_pkg.sv
  - hw/joy_port_mixer.sv
  - hw/boot_gate.sv
  - hw/ram_scrambler.sv
  - hw/audio_volume.sv
  - hw/st_glue_top.sv
  - target: simulation
    files:
      - verification/st_glue_tb.sv
